// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = qu_core_tb
FILELIST  = qu_core.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== common/qu_pkg.sv ====
// Core shared definitions
package qu_pkg;

    localparam int xlen = 32;

    typedef logic [31:0]      instr_t;
    typedef logic [xlen-1:0]  xword_t;
    typedef logic [4:0]       reg_idx_t;
    typedef logic [6:0]       opcode_t;
    typedef logic [2:0]       funct3_t;

    // rv32i major opcodes
    localparam opcode_t R_OPCODE       = 7'b0110011;
    localparam opcode_t I_OPCODE       = 7'b0010011;
    localparam opcode_t LOAD_OPCODE    = 7'b0000011;
    localparam opcode_t S_OPCODE       = 7'b0100011;
    localparam opcode_t B_OPCODE       = 7'b1100011;
    localparam opcode_t JAL_OPCODE     = 7'b1101111;
    localparam opcode_t JALR_OPCODE    = 7'b1100111;
    localparam opcode_t LUI_OPCODE     = 7'b0110111;
    localparam opcode_t AUIPC_OPCODE   = 7'b0010111;
    localparam opcode_t SYSCALL_OPCODE = 7'b1110011;
    localparam opcode_t CSR_OPCODE     = 7'b1110011; // csr ops live under the system opcode

    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_SLL     = 3'b001;
    localparam funct3_t FUNCT3_SLT     = 3'b010;
    localparam funct3_t FUNCT3_SLTU    = 3'b011;
    localparam funct3_t FUNCT3_XOR     = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
    localparam funct3_t FUNCT3_OR      = 3'b110;
    localparam funct3_t FUNCT3_AND     = 3'b111;

    typedef enum logic [3:0]
    {
        ALU_ADD      = 4'd0,
        ALU_SUB      = 4'd1,
        ALU_SLL      = 4'd2,
        ALU_SLT      = 4'd3,
        ALU_SLTU     = 4'd4,
        ALU_XOR      = 4'd5,
        ALU_SRL      = 4'd6,
        ALU_SRA      = 4'd7,
        ALU_OR       = 4'd8,
        ALU_AND      = 4'd9,
        ALU_PASS_IMM = 4'd10  // lui
    } alu_op_e;

    typedef enum logic [1:0]
    {
        OPTYPE_NONE        = 2'd0,
        OPTYPE_INT_ALU     = 2'd1,
        OPTYPE_UNSUPPORTED = 2'd2
    } optype_e;

    typedef enum logic [1:0]
    {
        STATUS_OK          = 2'd0,
        STATUS_NOP         = 2'd1,
        STATUS_INVALID     = 2'd2,
        STATUS_UNSUPPORTED = 2'd3
    } status_e;

    // decoded instruction
    typedef struct packed
    {
        optype_e  optype;
        alu_op_e  alu_op;
        reg_idx_t rs1;
        logic     rs1_valid;
        reg_idx_t rs2;
        logic     rs2_valid;
        reg_idx_t rd;
        logic     rd_valid;
        xword_t   imm;
        logic     imm_valid;
    } uop_t;

    typedef struct packed
    {
        reg_idx_t rd;
        xword_t   value;
        status_e  status;
    } result_t;

    typedef enum logic [1:0]
    {
        ISSUE_IDLE    = 2'd0,
        ISSUE_BUSY    = 2'd1,
        ISSUE_RELEASE = 2'd2
    } issue_state_e;

    typedef enum logic [1:0]
    {
        WB_IDLE     = 2'd0,
        WB_REQ      = 2'd1,
        WB_WAIT_LOW = 2'd2
    } wb_state_e;

endpackage

// ==== decode/decode.sv ====
// Instruction decoder
module decode
    (
        input  qu_pkg::instr_t instr,
        output logic           nop,
        output logic           invalid,
        output qu_pkg::uop_t   uop
    );

    qu_pkg::opcode_t  opcode;
    qu_pkg::reg_idx_t rd;
    qu_pkg::reg_idx_t rs1;
    qu_pkg::reg_idx_t rs2;
    qu_pkg::funct3_t  funct3;
    logic [6:0]       funct7;
    qu_pkg::xword_t   imm_i;
    qu_pkg::xword_t   imm_u;
    logic             writes_rd;
    logic             valid;

    function automatic qu_pkg::alu_op_e sel_alu_op
        (
            input qu_pkg::funct3_t f3,
            input logic            sub_sel,
            input logic            sra_sel
        );
        qu_pkg::alu_op_e op;
        case (f3)
            qu_pkg::FUNCT3_ADD_SUB: op = sub_sel ? qu_pkg::ALU_SUB : qu_pkg::ALU_ADD;
            qu_pkg::FUNCT3_SLL:     op = qu_pkg::ALU_SLL;
            qu_pkg::FUNCT3_SLT:     op = qu_pkg::ALU_SLT;
            qu_pkg::FUNCT3_SLTU:    op = qu_pkg::ALU_SLTU;
            qu_pkg::FUNCT3_XOR:     op = qu_pkg::ALU_XOR;
            qu_pkg::FUNCT3_SRL_SRA: op = sra_sel ? qu_pkg::ALU_SRA : qu_pkg::ALU_SRL;
            qu_pkg::FUNCT3_OR:      op = qu_pkg::ALU_OR;
            qu_pkg::FUNCT3_AND:     op = qu_pkg::ALU_AND;
            default:                op = qu_pkg::ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    assign writes_rd = (opcode == qu_pkg::R_OPCODE)    || (opcode == qu_pkg::I_OPCODE)
                    || (opcode == qu_pkg::LOAD_OPCODE) || (opcode == qu_pkg::LUI_OPCODE)
                    || (opcode == qu_pkg::AUIPC_OPCODE);

    assign nop = writes_rd && (rd == 5'd0);

    assign valid = (opcode == qu_pkg::R_OPCODE)       || (opcode == qu_pkg::I_OPCODE)
                || (opcode == qu_pkg::LOAD_OPCODE)    || (opcode == qu_pkg::S_OPCODE)
                || (opcode == qu_pkg::B_OPCODE)       || (opcode == qu_pkg::JAL_OPCODE)
                || (opcode == qu_pkg::JALR_OPCODE)    || (opcode == qu_pkg::LUI_OPCODE)
                || (opcode == qu_pkg::AUIPC_OPCODE)   || (opcode == qu_pkg::SYSCALL_OPCODE)
                || (opcode == qu_pkg::CSR_OPCODE);

    assign invalid = ~valid;

    always_comb
    begin
        uop = '0;

        if (opcode == qu_pkg::R_OPCODE)
        begin
            uop.optype    = qu_pkg::OPTYPE_INT_ALU;
            uop.rs1       = rs1;
            uop.rs1_valid = 1'b1;
            uop.rs2       = rs2;
            uop.rs2_valid = 1'b1;
            uop.rd        = rd;
            uop.rd_valid  = 1'b1;
            uop.alu_op    = sel_alu_op(funct3, funct7[5], funct7[5]);
        end
        else if (opcode == qu_pkg::I_OPCODE)
        begin
            uop.optype    = qu_pkg::OPTYPE_INT_ALU;
            uop.rs1       = rs1;
            uop.rs1_valid = 1'b1;
            uop.rd        = rd;
            uop.rd_valid  = 1'b1;
            uop.imm       = imm_i;
            uop.imm_valid = 1'b1;
            uop.alu_op    = sel_alu_op(funct3, 1'b0, funct7[5]); // bit 30 is imm for addi
        end
        else if (opcode == qu_pkg::LUI_OPCODE)
        begin
            uop.optype    = qu_pkg::OPTYPE_INT_ALU;
            uop.rd        = rd;
            uop.rd_valid  = 1'b1;
            uop.imm       = imm_u;
            uop.imm_valid = 1'b1;
            uop.alu_op    = qu_pkg::ALU_PASS_IMM;
        end
        else if (valid)
        begin
            uop.optype = qu_pkg::OPTYPE_UNSUPPORTED; // known but not executed here
        end
    end

endmodule

// ==== execute/alu.sv ====
// Integer ALU
module alu
    (
        input  qu_pkg::uop_t   uop,
        input  qu_pkg::xword_t rs1_data,
        input  qu_pkg::xword_t rs2_data,
        output qu_pkg::xword_t value
    );

    qu_pkg::xword_t op_a;
    qu_pkg::xword_t op_b;
    qu_pkg::xword_t sum;
    qu_pkg::xword_t diff;
    logic [4:0]     shamt;
    logic           lt;
    logic           ltu;

    assign op_a = uop.rs1_valid ? rs1_data : '0;
    assign op_b = uop.imm_valid ? uop.imm : (uop.rs2_valid ? rs2_data : '0);

    assign sum   = op_a + op_b;
    assign diff  = op_a - op_b;
    assign shamt = op_b[4:0]; // only the low five bits count

    assign lt  = $signed(op_a) < $signed(op_b);
    assign ltu = op_a < op_b;

    always_comb
    begin
        case (uop.alu_op)
            qu_pkg::ALU_ADD:
                value = sum;
            qu_pkg::ALU_SUB:
                value = diff;
            qu_pkg::ALU_SLL:
                value = op_a << shamt;
            qu_pkg::ALU_SLT:
                value = {{(qu_pkg::xlen-1){1'b0}}, lt};
            qu_pkg::ALU_SLTU:
                value = {{(qu_pkg::xlen-1){1'b0}}, ltu};
            qu_pkg::ALU_XOR:
                value = op_a ^ op_b;
            qu_pkg::ALU_SRL:
                value = op_a >> shamt;
            qu_pkg::ALU_SRA:
                value = $signed(op_a) >>> shamt;
            qu_pkg::ALU_OR:
                value = op_a | op_b;
            qu_pkg::ALU_AND:
                value = op_a & op_b;
            qu_pkg::ALU_PASS_IMM:
                value = uop.imm;
            default:
                value = '0;
        endcase
    end

endmodule

// ==== logic/issue_ctrl.sv ====
// Instruction issue control
module issue_ctrl
    (
        input  logic           clk,
        input  logic           rst_n,
        input  qu_pkg::instr_t instr,
        input  logic           instr_req,
        output logic           instr_ack,
        input  logic           wb_idle,
        output qu_pkg::instr_t instr_q,
        output logic           issue_valid
    );

    qu_pkg::issue_state_e state;
    logic                 capture;

    // one instruction in flight, wait for the result side to drain
    assign capture = (state == qu_pkg::ISSUE_IDLE) && instr_req && wb_idle;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= qu_pkg::ISSUE_IDLE;
            instr_ack   <= 1'b0;
            issue_valid <= 1'b0;
        end
        else
        begin
            issue_valid <= capture; // single cycle pulse
            case (state)
                qu_pkg::ISSUE_IDLE:
                begin
                    if (capture)
                    begin
                        instr_ack <= 1'b1;
                        state     <= qu_pkg::ISSUE_BUSY;
                    end
                end
                qu_pkg::ISSUE_BUSY:
                begin
                    if (!instr_req)
                    begin
                        instr_ack <= 1'b0;
                        state     <= qu_pkg::ISSUE_RELEASE;
                    end
                end
                qu_pkg::ISSUE_RELEASE:
                begin
                    if (wb_idle)
                        state <= qu_pkg::ISSUE_IDLE;
                end
                default: state <= qu_pkg::ISSUE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
            instr_q <= instr;
    end

endmodule

// ==== logic/qu_core.sv ====
// Integer core top level
module qu_core
    (
        input  logic            clk,
        input  logic            rst_n,
        input  qu_pkg::instr_t  instr,
        input  logic            instr_req,
        output logic            instr_ack,
        output qu_pkg::result_t result,
        output logic            res_req,
        input  logic            res_ack
    );

    qu_pkg::instr_t   instr_q;
    logic             issue_valid;
    logic             wb_idle;
    qu_pkg::uop_t     uop;
    logic             nop;
    logic             invalid;
    qu_pkg::xword_t   rs1_data;
    qu_pkg::xword_t   rs2_data;
    qu_pkg::xword_t   alu_value;
    logic             wr_en;
    qu_pkg::reg_idx_t wr_idx;
    qu_pkg::xword_t   wr_data;

    issue_ctrl u_issue_ctrl
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_req   (instr_req),
        .instr_ack   (instr_ack),
        .wb_idle     (wb_idle),
        .instr_q     (instr_q),
        .issue_valid (issue_valid)
    );

    decode u_decode
    (
        .instr   (instr_q),
        .nop     (nop),
        .invalid (invalid),
        .uop     (uop)
    );

    reg_file u_reg_file
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (uop.rs1),
        .rs2_idx  (uop.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data)
    );

    alu u_alu
    (
        .uop      (uop),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .value    (alu_value)
    );

    writeback u_writeback
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .uop         (uop),
        .nop         (nop),
        .invalid     (invalid),
        .value       (alu_value),
        .wb_idle     (wb_idle),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .result      (result),
        .res_req     (res_req),
        .res_ack     (res_ack)
    );

endmodule

// ==== logic/reg_file.sv ====
// Integer register file
module reg_file
    (
        input  logic             clk,
        input  logic             rst_n,
        input  qu_pkg::reg_idx_t rs1_idx,
        input  qu_pkg::reg_idx_t rs2_idx,
        output qu_pkg::xword_t   rs1_data,
        output qu_pkg::xword_t   rs2_data,
        input  logic             wr_en,
        input  qu_pkg::reg_idx_t wr_idx,
        input  qu_pkg::xword_t   wr_data
    );

    qu_pkg::xword_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en && (wr_idx != 5'd0))
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

// ==== logic/writeback.sv ====
// Result stage and result port
module writeback
    (
        input  logic             clk,
        input  logic             rst_n,
        input  logic             issue_valid,
        input  qu_pkg::uop_t     uop,
        input  logic             nop,
        input  logic             invalid,
        input  qu_pkg::xword_t   value,
        output logic             wb_idle,
        output logic             wr_en,
        output qu_pkg::reg_idx_t wr_idx,
        output qu_pkg::xword_t   wr_data,
        output qu_pkg::result_t  result,
        output logic             res_req,
        input  logic             res_ack
    );

    qu_pkg::wb_state_e state;
    qu_pkg::status_e   status;
    logic              accept;

    // status priority: invalid, unsupported, nop, ok
    always_comb
    begin
        if (invalid)
            status = qu_pkg::STATUS_INVALID;
        else if (uop.optype == qu_pkg::OPTYPE_UNSUPPORTED)
            status = qu_pkg::STATUS_UNSUPPORTED;
        else if (nop)
            status = qu_pkg::STATUS_NOP;
        else
            status = qu_pkg::STATUS_OK;
    end

    assign accept  = issue_valid && (state == qu_pkg::WB_IDLE);
    assign wb_idle = (state == qu_pkg::WB_IDLE);

    // register write lands on the same edge the record is latched
    assign wr_en   = accept && uop.rd_valid && (status == qu_pkg::STATUS_OK);
    assign wr_idx  = uop.rd;
    assign wr_data = value;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= qu_pkg::WB_IDLE;
            res_req <= 1'b0;
        end
        else
        begin
            case (state)
                qu_pkg::WB_IDLE:
                begin
                    if (accept)
                    begin
                        res_req <= 1'b1;
                        state   <= qu_pkg::WB_REQ;
                    end
                end
                qu_pkg::WB_REQ:
                begin
                    if (res_ack)
                    begin
                        res_req <= 1'b0;
                        state   <= qu_pkg::WB_WAIT_LOW;
                    end
                end
                qu_pkg::WB_WAIT_LOW:
                begin
                    if (!res_ack)
                        state <= qu_pkg::WB_IDLE;
                end
                default: state <= qu_pkg::WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            result.rd     <= uop.rd;
            result.value  <= (status == qu_pkg::STATUS_OK) ? value : '0;
            result.status <= status;
        end
    end

endmodule

// ==== qu_core.f ====
common/qu_pkg.sv
logic/issue_ctrl.sv
decode/decode.sv
execute/alu.sv
logic/reg_file.sv
logic/writeback.sv
logic/qu_core.sv
verification/qu_core_asserts.sv
verification/qu_core_tb.sv

// ==== verification/qu_core_asserts.sv ====
// Handshake and reset assertions
module qu_core_asserts
    (
        input logic            clk,
        input logic            rst_n,
        input logic            instr_ack,
        input logic            res_req,
        input logic            res_ack,
        input qu_pkg::result_t result
    );

    timeunit 1ns;
    timeprecision 100ps;

    // both ports quiet while in reset
    reset_quiet: assert property (@(posedge clk) !rst_n |-> (!instr_ack && !res_req))
        else $error("instr_ack or res_req high during reset");

    // sender holds the record until acknowledged
    result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (res_req && !res_ack) |=> $stable(result))
        else $error("result changed while res_req high and res_ack low");

    // a new capture only once the previous result has gone
    capture_clear: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(instr_ack) |-> !res_req)
        else $error("instr_ack rose while a result was still pending");

endmodule

bind qu_core qu_core_asserts u_asserts
(
    .clk       (clk),
    .rst_n     (rst_n),
    .instr_ack (instr_ack),
    .res_req   (res_req),
    .res_ack   (res_ack),
    .result    (result)
);

// ==== verification/qu_core_tb.sv ====
// Integer core testbench
module qu_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TMO = 50;  // cycles per wait
    localparam int NRAND = 40;

    typedef struct packed
    {
        qu_pkg::instr_t   instr;
        qu_pkg::reg_idx_t rd;
        qu_pkg::xword_t   value;
        qu_pkg::status_e  status;
    } entry_t;

    logic            clk;
    logic            rst_n;
    qu_pkg::instr_t  instr;
    logic            instr_req;
    logic            instr_ack;
    qu_pkg::result_t result;
    logic            res_req;
    logic            res_ack;

    entry_t         table_q[$];
    qu_pkg::xword_t model [0:31];
    integer         seed = 32'h9d07;
    logic           req_up = 1'b0;  // next request already raised early

    qu_core UUT
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .instr_req (instr_req),
        .instr_ack (instr_ack),
        .result    (result),
        .res_req   (res_req),
        .res_ack   (res_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input qu_pkg::xword_t got,
                               input qu_pkg::xword_t exp);
        if (got !== exp)
            fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_idx(input string name, input qu_pkg::reg_idx_t got,
                             input qu_pkg::reg_idx_t exp);
        if (got !== exp)
            fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_status(input string name, input qu_pkg::status_e got,
                                input qu_pkg::status_e exp);
        if (got !== exp)
            fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    function automatic qu_pkg::instr_t enc_r(input logic [6:0] f7, input qu_pkg::reg_idx_t rs2,
        input qu_pkg::reg_idx_t rs1, input logic [2:0] f3, input qu_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, qu_pkg::R_OPCODE};
    endfunction

    function automatic qu_pkg::instr_t enc_i(input logic [11:0] imm, input qu_pkg::reg_idx_t rs1,
        input logic [2:0] f3, input qu_pkg::reg_idx_t rd, input qu_pkg::opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic void add_entry(input qu_pkg::instr_t w, input qu_pkg::reg_idx_t rd,
        input qu_pkg::xword_t v, input qu_pkg::status_e st);
        entry_t e;
        e.instr  = w;
        e.rd     = rd;
        e.value  = v;
        e.status = st;
        table_q.push_back(e);
    endfunction

    // reference ALU for the random run: 0 addi, 1 add, 2 sub, 3 xor, 4 slt, 5 sll, 6 sra
    function automatic qu_pkg::xword_t model_alu(input int kind, input qu_pkg::xword_t a,
                                                 input qu_pkg::xword_t b);
        case (kind)
            0, 1:    return a + b;
            2:       return a - b;
            3:       return a ^ b;
            4:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            5:       return a << b[4:0];
            default: return $signed(a) >>> b[4:0];
        endcase
    endfunction

    task automatic wait_ack(input logic level);
        int cnt;
        cnt = 0;
        while (instr_ack !== level)
        begin
            @(negedge clk);
            cnt++;
            if (cnt > TMO)
                fail_run("timeout: instruction port did not move instr_ack");
        end
    endtask

    // one instruction through both handshakes, with a random res_ack delay
    task automatic run_one(input entry_t e, input logic has_nxt, input qu_pkg::instr_t nxt);
        int cnt;
        int d;
        logic fresh;
        qu_pkg::result_t held;
        fresh = !req_up;
        if (fresh)
        begin
            repeat (2) @(posedge clk); // issue side returns to idle a cycle after writeback
            instr     <= e.instr;
            instr_req <= 1'b1;
        end
        req_up = 1'b0;
        cnt = 0;
        while (!res_req)
        begin
            @(negedge clk);
            cnt++;
            if (cnt > TMO)
                fail_run("timeout: result port never raised res_req");
        end
        if (fresh && cnt != 3)
            fail_run($sformatf("error: res_req latency got %h expected %h", cnt - 1, 2));
        check_idx("result.rd", result.rd, e.rd);
        check_value("result.value", result.value, e.value);
        check_status("result.status", result.status, e.status);
        wait_ack(1'b1);
        @(posedge clk);
        instr_req <= 1'b0;
        wait_ack(1'b0);
        held = result;
        d = $unsigned($random(seed)) % 11;
        for (int k = 0; k < d; k++)
        begin
            @(posedge clk);
            if (has_nxt && !req_up)
            begin
                instr     <= nxt;
                instr_req <= 1'b1;
                req_up = 1'b1;
            end
            @(negedge clk);
            if (!res_req)
                fail_run("res_req dropped before res_ack was raised");
            if (instr_ack)
                fail_run("instr_ack raised while the result handshake was still open");
            check_value("result.value", result.value, held.value);
            check_idx("result.rd", result.rd, held.rd);
            check_status("result.status", result.status, held.status);
        end
        @(posedge clk);
        if (has_nxt && !req_up)
        begin
            instr     <= nxt;
            instr_req <= 1'b1;
            req_up = 1'b1;
        end
        res_ack <= 1'b1;
        cnt = 0;
        while (res_req)
        begin
            @(negedge clk);
            cnt++;
            if (instr_ack)
                fail_run("instr_ack raised while the result handshake was still open");
            if (cnt > TMO)
                fail_run("timeout: result port never dropped res_req");
        end
        @(posedge clk);
        res_ack <= 1'b0;
        if (e.status == qu_pkg::STATUS_OK)
            model[e.rd] = e.value;
    endtask

    initial
    begin
        int kind [NRAND];
        qu_pkg::reg_idx_t rd [NRAND];
        qu_pkg::reg_idx_t rs1 [NRAND];
        qu_pkg::reg_idx_t rs2 [NRAND];
        logic [11:0] imm [NRAND];
        qu_pkg::instr_t words [NRAND];
        logic [2:0] f3_of [7];
        entry_t e;
        qu_pkg::xword_t b;

        rst_n     = 1'b0;
        instr     = '0;
        instr_req = 1'b0;
        res_ack   = 1'b0;
        for (int i = 0; i < 32; i++)
            model[i] = '0;

        add_entry(enc_i(12'd5, 0, 3'b000, 1, qu_pkg::I_OPCODE), 1, 32'h5, qu_pkg::STATUS_OK);
        add_entry(enc_i(12'hffd, 0, 3'b000, 2, qu_pkg::I_OPCODE), 2, 32'hfffffffd,
                  qu_pkg::STATUS_OK);
        add_entry(enc_r(7'h00, 2, 1, 3'b000, 3), 3, 32'h2, qu_pkg::STATUS_OK);
        add_entry(enc_r(7'h20, 2, 1, 3'b000, 4), 4, 32'h8, qu_pkg::STATUS_OK);
        add_entry(enc_r(7'h20, 1, 2, 3'b101, 5), 5, 32'hffffffff, qu_pkg::STATUS_OK);
        add_entry(enc_r(7'h00, 1, 2, 3'b101, 6), 6, 32'h07ffffff, qu_pkg::STATUS_OK);
        add_entry(enc_r(7'h00, 1, 1, 3'b001, 7), 7, 32'ha0, qu_pkg::STATUS_OK);
        add_entry(enc_r(7'h00, 1, 2, 3'b010, 8), 8, 32'h1, qu_pkg::STATUS_OK);
        add_entry(enc_r(7'h00, 1, 2, 3'b011, 9), 9, 32'h0, qu_pkg::STATUS_OK);
        add_entry(enc_r(7'h00, 2, 1, 3'b100, 10), 10, 32'hfffffff8, qu_pkg::STATUS_OK);
        add_entry(enc_r(7'h00, 2, 1, 3'b110, 11), 11, 32'hfffffffd, qu_pkg::STATUS_OK);
        add_entry(enc_r(7'h00, 2, 1, 3'b111, 12), 12, 32'h5, qu_pkg::STATUS_OK);
        add_entry(enc_i(12'd0, 2, 3'b010, 13, qu_pkg::I_OPCODE), 13, 32'h1, qu_pkg::STATUS_OK);
        add_entry(enc_i(12'd1, 2, 3'b011, 14, qu_pkg::I_OPCODE), 14, 32'h0, qu_pkg::STATUS_OK);
        add_entry(enc_i(12'hfff, 1, 3'b100, 15, qu_pkg::I_OPCODE), 15, 32'hfffffffa,
                  qu_pkg::STATUS_OK);
        add_entry(enc_i(12'h010, 1, 3'b110, 16, qu_pkg::I_OPCODE), 16, 32'h15, qu_pkg::STATUS_OK);
        add_entry(enc_i(12'h00f, 2, 3'b111, 17, qu_pkg::I_OPCODE), 17, 32'hd, qu_pkg::STATUS_OK);
        add_entry(enc_i(12'h004, 1, 3'b001, 18, qu_pkg::I_OPCODE), 18, 32'h50, qu_pkg::STATUS_OK);
        add_entry(enc_i(12'h01c, 2, 3'b101, 19, qu_pkg::I_OPCODE), 19, 32'hf, qu_pkg::STATUS_OK);
        add_entry(enc_i(12'h401, 2, 3'b101, 20, qu_pkg::I_OPCODE), 20, 32'hfffffffe,
                  qu_pkg::STATUS_OK);
        add_entry(enc_i(12'd7, 1, 3'b000, 0, qu_pkg::I_OPCODE), 0, 32'h0, qu_pkg::STATUS_NOP);
        add_entry(enc_r(7'h00, 1, 0, 3'b000, 21), 21, 32'h5, qu_pkg::STATUS_OK);
        add_entry({20'h12345, 5'd22, qu_pkg::LUI_OPCODE}, 22, 32'h12345000, qu_pkg::STATUS_OK);
        // known but not executed, rd of the record stays zero
        add_entry(enc_i(12'd0, 2, 3'b010, 1, qu_pkg::LOAD_OPCODE), 0, 0,
                  qu_pkg::STATUS_UNSUPPORTED);
        add_entry({7'h0, 5'd1, 5'd2, 3'b010, 5'd0, qu_pkg::S_OPCODE}, 0, 0,
                  qu_pkg::STATUS_UNSUPPORTED);
        add_entry({7'h0, 5'd1, 5'd2, 3'b000, 5'd0, qu_pkg::B_OPCODE}, 0, 0,
                  qu_pkg::STATUS_UNSUPPORTED);
        add_entry({20'h0, 5'd1, qu_pkg::JAL_OPCODE}, 0, 0, qu_pkg::STATUS_UNSUPPORTED);
        add_entry(enc_i(12'h300, 2, 3'b001, 1, qu_pkg::CSR_OPCODE), 0, 0,
                  qu_pkg::STATUS_UNSUPPORTED);
        add_entry({25'h0000021, 7'b1111111}, 0, 0, qu_pkg::STATUS_INVALID);
        add_entry(enc_r(7'h00, 0, 1, 3'b000, 23), 23, 32'h5, qu_pkg::STATUS_OK);
        add_entry(enc_r(7'h00, 0, 0, 3'b000, 24), 24, 32'h0, qu_pkg::STATUS_OK);

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        foreach (table_q[i])
            run_one(table_q[i], 1'b0, '0);

        f3_of = '{3'b000, 3'b000, 3'b000, 3'b100, 3'b010, 3'b001, 3'b101};
        for (int i = 0; i < NRAND; i++)
        begin
            kind[i] = $unsigned($random(seed)) % 7;
            rd[i]   = 5'($unsigned($random(seed)) % 7 + 1);
            rs1[i]  = 5'($unsigned($random(seed)) % 7 + 1);
            rs2[i]  = 5'($unsigned($random(seed)) % 7 + 1);
            imm[i]  = 12'($random(seed));
            if (kind[i] == 0)
                words[i] = enc_i(imm[i], rs1[i], 3'b000, rd[i], qu_pkg::I_OPCODE);
            else
                words[i] = enc_r((kind[i] == 2 || kind[i] == 6) ? 7'h20 : 7'h00,
                                 rs2[i], rs1[i], f3_of[kind[i]], rd[i]);
        end
        for (int i = 0; i < NRAND; i++)
        begin
            b = (kind[i] == 0) ? {{20{imm[i][11]}}, imm[i]} : model[rs2[i]];
            e.instr  = words[i];
            e.rd     = rd[i];
            e.value  = model_alu(kind[i], model[rs1[i]], b);
            e.status = qu_pkg::STATUS_OK;
            run_one(e, i < NRAND - 1, (i < NRAND - 1) ? words[i + 1] : '0);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule
